// ==== Makefile ====
# Verilator build and run for the board control testbench

VERILATOR ?= verilator
TOP       ?= board_ctrl_tb
FILELIST  ?= files.f
BUILD_DIR ?= obj_dir
LOG       ?= sim.log
PASS_MSG  ?= All tests passed!
VFLAGS    ?= --timing --assert
JOBS      ?= 0

SIM_BIN := $(BUILD_DIR)/V$(TOP)
SOURCES := $(shell cat $(FILELIST))

.PHONY: all build run lint clean

all: run

build: $(SIM_BIN)

$(SIM_BIN): $(FILELIST) $(SOURCES)
	$(VERILATOR) --binary $(VFLAGS) -j $(JOBS) --top-module $(TOP) \
		--Mdir $(BUILD_DIR) -f $(FILELIST)

run: $(SIM_BIN)
	./$(SIM_BIN) | tee $(LOG)
	@if grep -qF "$(PASS_MSG)" $(LOG); then \
		echo "simulation passed"; \
	else \
		echo "simulation failed, see $(LOG)"; \
		exit 1; \
	fi

lint:
	$(VERILATOR) --lint-only $(VFLAGS) --top-module $(TOP) -f $(FILELIST)

clean:
	rm -rf $(BUILD_DIR) $(LOG)

// ==== files.f ====
verilog/board_io_pkg.sv
verilog/icap_cfg_pkg.sv
verilog/gpio_debounce.sv
verilog/pcs_status_mon.sv
verilog/icap_reboot_seq.sv
verilog/board_ctrl_top.sv
verification/board_ctrl_tb.sv

// ==== verification/board_ctrl_tb.sv ====
// Board control testbench
module board_ctrl_tb;

timeunit 1ns;
timeprecision 100ps;

import board_io_pkg::*;
import icap_cfg_pkg::*;

localparam int RATE = 8;
localparam int SETTLE_CYCLES = (DEBOUNCE_DEPTH + 2) * RATE;
localparam int BOOT_TIMEOUT = 20;

// stable GPIO patterns, buttons then switches
localparam gpio_raw_t GPIO_A = 9'b10101_0101;
localparam gpio_raw_t GPIO_B = 9'b01010_0010;
localparam gpio_raw_t DEBUG_LO = 9'b00000_1000;
localparam gpio_raw_t DEBUG_HI = 9'b00000_1001;

// reboot words in the order they leave the port
localparam icap_word_t SEQ_WORDS [6] = '{
    ICAP_DUMMY, ICAP_SYNC, ICAP_NOOP, ICAP_WRITE_CMD, ICAP_IPROG, ICAP_NOOP
};

logic clk_125mhz_int;
logic rst;
gpio_raw_t gpio_in;
led_t led;
pcs_status_t pcs_status;
logic speed_is_10_100;
logic speed_is_100;
logic fpga_boot;
logic icap_avail;
logic icap_csib;
icap_word_t icap_di;

int errors = 0;
int sva_errors = 0;
int err_mark = 0;
int tests_run = 0;
int tests_failed = 0;
logic [31:0] rng_state = 32'hd9d6a7bd;

board_ctrl_top #(
    .RATE(RATE)
)
dut0 (
    .clk_125mhz_int(clk_125mhz_int),
    .rst(rst),
    .gpio_in(gpio_in),
    .led(led),
    .pcs_status(pcs_status),
    .speed_is_10_100(speed_is_10_100),
    .speed_is_100(speed_is_100),
    .fpga_boot(fpga_boot),
    .icap_avail(icap_avail),
    .icap_csib(icap_csib),
    .icap_di(icap_di)
);

initial clk_125mhz_int = 1'b0;
always #4 clk_125mhz_int = ~clk_125mhz_int;

// speed hints must always match the status field
assert property (@(posedge clk_125mhz_int) disable iff (rst)
    (speed_is_10_100 == (pcs_status[11:10] != 2'd2)) &&
    (speed_is_100 == (pcs_status[11:10] == 2'd1)))
else begin
    sva_errors++;
    $display("[ERROR] %0t: speed flags %b %b wrong for speed code %0d",
             $time, speed_is_10_100, speed_is_100, pcs_status[11:10]);
end

function automatic logic [31:0] lcg_next(input logic [31:0] s);
    return s * 32'd1664525 + 32'd1013904223;
endfunction

// each byte mirrored, bytes stay in place
function automatic icap_word_t reverse_byte_bits(input icap_word_t w);
    icap_word_t r;
    logic [7:0] byte_v;
    for (int b = 0; b < 4; b++) begin
        byte_v = w[8*b +: 8];
        r[8*b +: 8] = {<<{byte_v}};
    end
    return r;
endfunction

function automatic led_t normal_led(input gpio_raw_t g);
    return {g.btnu, g.btnl, g.btnd, g.btnr, g.btnc, g.sw[2:0]};
endfunction

task automatic step();
    @(posedge clk_125mhz_int);
    #1;
endtask

task automatic mark_test_start();
    err_mark = errors + sva_errors;
endtask

task automatic report_test(input string name);
    int n;
    n = errors + sva_errors - err_mark;
    tests_run++;
    if (n == 0) begin
        $display("test %s: ok", name);
    end else begin
        tests_failed++;
        $display("test %s: FAILED with %0d errors", name, n);
    end
endtask

task automatic check_led(input led_t exp);
    assert (led == exp) else begin
        errors++;
        $display("[ERROR] %0t: led is %h, expected %h", $time, led, exp);
    end
endtask

task automatic check_csib(input logic exp);
    assert (icap_csib == exp) else begin
        errors++;
        $display("[ERROR] %0t: icap_csib is %b, expected %b", $time, icap_csib, exp);
    end
endtask

task automatic wait_for_led(input led_t exp, input string what);
    int cycles;
    cycles = 0;
    while (led != exp && cycles < SETTLE_CYCLES) begin
        step();
        cycles++;
    end
    assert (led == exp) else begin
        errors++;
        $display("timed out after %0d cycles waiting for led to show the %s", cycles, what);
    end
endtask

task automatic drive_random_status(input logic high_byte);
    repeat (16) begin
        rng_state = lcg_next(rng_state);
        pcs_status = pcs_status_t'(rng_state[31:16]);
        step();
        check_led(high_byte ? pcs_status[15:8] : pcs_status[7:0]);
    end
endtask

initial begin
    int cycles;
    rst = 1'b1;
    gpio_in = '0;
    pcs_status = '0;
    fpga_boot = 1'b0;
    icap_avail = 1'b0;

    mark_test_start();
    repeat (5) step();
    rst = 1'b0;
    step();
    check_led(8'h00);
    check_csib(1'b1);
    repeat (10) begin
        step();
        check_csib(1'b1);
    end
    // request without the port being available
    fpga_boot = 1'b1;
    repeat (10) begin
        step();
        check_csib(1'b1);
    end
    fpga_boot = 1'b0;
    repeat (4) step();
    report_test("reset state");

    mark_test_start();
    gpio_in = GPIO_A;
    wait_for_led(normal_led(GPIO_A), "first stable value");
    // led moves one cycle after a sample, so this puts the glitch over the next sample
    repeat (RATE / 2) step();
    // glitch shorter than one sample period
    gpio_in = GPIO_B;
    repeat (4) step();
    gpio_in = GPIO_A;
    repeat (SETTLE_CYCLES) begin
        step();
        check_led(normal_led(GPIO_A));
    end
    gpio_in = GPIO_B;
    wait_for_led(normal_led(GPIO_B), "second stable value");
    report_test("debounce");

    mark_test_start();
    pcs_status = pcs_status_t'(16'h5aa5);
    gpio_in = DEBUG_LO;
    wait_for_led(8'ha5, "status low byte");
    drive_random_status(1'b0);
    pcs_status = pcs_status_t'(16'h5aa5);
    gpio_in = DEBUG_HI;
    wait_for_led(8'h5a, "status high byte");
    drive_random_status(1'b1);
    report_test("debug led select");

    mark_test_start();
    for (int c = 0; c < 3; c++) begin
        pcs_status.speed = pcs_speed_t'(c[1:0]);
        #1;
        assert (speed_is_10_100 == (c != 2) && speed_is_100 == (c == 1)) else begin
            errors++;
            $display("[ERROR] %0t: speed code %0d gave flags %b %b",
                     $time, c, speed_is_10_100, speed_is_100);
        end
        step();
    end
    report_test("speed flags");

    mark_test_start();
    icap_avail = 1'b1;
    step();
    check_csib(1'b1);
    assert (icap_di == reverse_byte_bits(ICAP_DUMMY)) else begin
        errors++;
        $display("[ERROR] %0t: idle icap_di is %h", $time, icap_di);
    end
    // three cycle request pulse
    fpga_boot = 1'b1;
    cycles = 0;
    while (icap_csib && cycles < BOOT_TIMEOUT) begin
        step();
        cycles++;
        if (cycles == 3) begin
            fpga_boot = 1'b0;
        end
    end
    fpga_boot = 1'b0;
    assert (!icap_csib) else begin
        errors++;
        $display("icap_csib never went low after the reboot request");
    end
    assert (cycles == 3) else begin
        errors++;
        $display("[ERROR] %0t: icap_csib fell after %0d cycles, expected 3", $time, cycles);
    end
    for (int k = 0; k < 6; k++) begin
        check_csib(1'b0);
        assert (icap_di == reverse_byte_bits(SEQ_WORDS[k])) else begin
            errors++;
            $display("[ERROR] %0t: word %0d is %h, expected %h",
                     $time, k, icap_di, reverse_byte_bits(SEQ_WORDS[k]));
        end
        step();
    end
    check_csib(1'b1);
    repeat (8) begin
        step();
        check_csib(1'b1);
    end
    icap_avail = 1'b0;
    report_test("reboot sequence");

    $display("%0d tests run, %0d failed, %0d assertion errors",
             tests_run, tests_failed, errors + sva_errors);
    if (tests_failed == 0 && errors + sva_errors == 0) begin
        $display("All tests passed!");
    end else begin
        $display("Test failures found");
    end
    $finish;
end

endmodule

// ==== verilog/board_ctrl_top.sv ====
// Board control top level
module board_ctrl_top #(
    parameter int RATE = board_io_pkg::DEBOUNCE_RATE
) (
    input  logic                      clk_125mhz_int,
    input  logic                      rst,

    // buttons, switches and LEDs
    input  board_io_pkg::gpio_raw_t   gpio_in,
    output board_io_pkg::led_t        led,

    // SGMII PCS/PMA status and speed control
    input  board_io_pkg::pcs_status_t pcs_status,
    output logic                      speed_is_10_100,
    output logic                      speed_is_100,

    // reboot request and configuration port
    input  logic                      fpga_boot,
    input  logic                      icap_avail,
    output logic                      icap_csib,
    output icap_cfg_pkg::icap_word_t  icap_di
);

import board_io_pkg::*;

gpio_raw_t gpio_db;

gpio_debounce #(
    .RATE(RATE)
)
gpio_debounce_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .rst(rst),
    .gpio_in(gpio_in),
    .gpio_db(gpio_db)
);

// LEDs follow the debounced switches
pcs_status_mon
pcs_status_mon_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .rst(rst),
    .gpio_db(gpio_db),
    .pcs_status(pcs_status),
    .speed_is_10_100(speed_is_10_100),
    .speed_is_100(speed_is_100),
    .led(led)
);

icap_reboot_seq
icap_reboot_seq_inst (
    .clk_125mhz_int(clk_125mhz_int),
    .rst(rst),
    .fpga_boot(fpga_boot),
    .icap_avail(icap_avail),
    .icap_csib(icap_csib),
    .icap_di(icap_di)
);

endmodule

// ==== verilog/board_io_pkg.sv ====
// Board GPIO and PCS status types
package board_io_pkg;

// push buttons and slide switches, in board order
typedef struct packed {
    logic       btnu;
    logic       btnl;
    logic       btnd;
    logic       btnr;
    logic       btnc;
    logic [3:0] sw;
} gpio_raw_t;

localparam int GPIO_W = $bits(gpio_raw_t);

// LED byte, led[7] is the leftmost LED
typedef logic [7:0] led_t;

// link speed code reported by the SGMII PCS/PMA
typedef enum logic [1:0] {
    SPEED_10   = 2'd0,
    SPEED_100  = 2'd1,
    SPEED_1000 = 2'd2
} pcs_speed_t;

// PCS/PMA status vector, MSB first
typedef struct packed {
    logic [1:0] pause;
    logic       remote_fault;
    logic       duplex;
    pcs_speed_t speed;
    logic [1:0] remote_fault_encdg;
    logic       phy_link_status;
    logic       rxnotintable;
    logic       rxdisperr;
    logic       rudi_invalid;
    logic       rudi_i;
    logic       rudi_c;
    logic       link_synchronization;
    logic       link_status;
} pcs_status_t;

// 1 ms between samples at 125 MHz
localparam int DEBOUNCE_RATE = 125000;

// samples that must agree before an output changes
localparam int DEBOUNCE_DEPTH = 4;

endpackage

// ==== verilog/gpio_debounce.sv ====
// Button and switch debouncer
module gpio_debounce #(
    parameter int RATE = board_io_pkg::DEBOUNCE_RATE
) (
    input  logic                    clk_125mhz_int,
    input  logic                    rst,
    input  board_io_pkg::gpio_raw_t gpio_in,
    output board_io_pkg::gpio_raw_t gpio_db
);

import board_io_pkg::*;

// sample counter runs 0 .. RATE-1
localparam int CNT_W = $clog2(RATE + 1);
localparam logic [CNT_W-1:0] CNT_LAST = CNT_W'(RATE - 1);

logic [CNT_W-1:0] cnt_reg;
logic sample_stb;

logic [GPIO_W-1:0] in_bits;
logic [GPIO_W-1:0][DEBOUNCE_DEPTH-1:0] hist_reg;
logic [GPIO_W-1:0][DEBOUNCE_DEPTH-1:0] hist_next;
logic [GPIO_W-1:0] db_reg;

assign in_bits = gpio_in;
assign sample_stb = (cnt_reg == CNT_LAST);

always_ff @(posedge clk_125mhz_int) begin
    if (rst) begin
        cnt_reg <= '0;
    end else if (sample_stb) begin
        cnt_reg <= '0;
    end else begin
        cnt_reg <= cnt_reg + 1'b1;
    end
end

// history after this sample, newest bit in position 0
always_comb begin
    for (int i = 0; i < GPIO_W; i++) begin
        hist_next[i] = {hist_reg[i][DEBOUNCE_DEPTH-2:0], in_bits[i]};
    end
end

always_ff @(posedge clk_125mhz_int) begin
    if (rst) begin
        hist_reg <= '0;
        db_reg <= '0;
    end else if (sample_stb) begin
        hist_reg <= hist_next;
        for (int i = 0; i < GPIO_W; i++) begin
            // mixed history keeps the previous level
            if (&hist_next[i]) begin
                db_reg[i] <= 1'b1;
            end else if (!(|hist_next[i])) begin
                db_reg[i] <= 1'b0;
            end
        end
    end
end

assign gpio_db = gpio_raw_t'(db_reg);

endmodule

// ==== verilog/icap_cfg_pkg.sv ====
// Configuration port command set
package icap_cfg_pkg;

// one configuration-port word, in normal bit order
typedef logic [31:0] icap_word_t;

// bus width detection filler
localparam icap_word_t ICAP_DUMMY = 32'hFFFFFFFF;

// sync word, aligns the packet processor
localparam icap_word_t ICAP_SYNC = 32'hAA995566;

// type 1 noop
localparam icap_word_t ICAP_NOOP = 32'h20000000;

// type 1 write of one word to the CMD register
localparam icap_word_t ICAP_WRITE_CMD = 32'h30008001;

// IPROG command, reloads from the warm boot address
localparam icap_word_t ICAP_IPROG = 32'h0000000F;

// reboot sequencer states
// each active state names the word loaded on its exit edge
typedef enum logic [2:0] {
    SEQ_IDLE,
    SEQ_SYNC,
    SEQ_NOOP0,
    SEQ_WRCMD,
    SEQ_IPROG,
    SEQ_NOOP1
} icap_seq_state_t;

endpackage

// ==== verilog/icap_reboot_seq.sv ====
// IPROG reboot sequencer
module icap_reboot_seq (
    input  logic                     clk_125mhz_int,
    input  logic                     rst,
    input  logic                     fpga_boot,
    input  logic                     icap_avail,
    output logic                     icap_csib,
    output icap_cfg_pkg::icap_word_t icap_di
);

import icap_cfg_pkg::*;

logic [1:0] boot_sync_reg;
logic boot_req;
logic start_seq;

icap_seq_state_t state_reg;
logic csib_reg;

icap_word_t word_next;
icap_word_t word_reg;

// two-flop synchronizer for the request level
always_ff @(posedge clk_125mhz_int) begin
    if (rst) begin
        boot_sync_reg <= '0;
    end else begin
        boot_sync_reg <= {boot_sync_reg[0], fpga_boot};
    end
end

assign boot_req = boot_sync_reg[1];

// csib high means at least one deselected cycle since the last sequence
assign start_seq = csib_reg && boot_req && icap_avail;

always_ff @(posedge clk_125mhz_int) begin
    if (rst) begin
        state_reg <= SEQ_IDLE;
        csib_reg <= 1'b1;
    end else begin
        case (state_reg)
            SEQ_IDLE: begin
                csib_reg <= !start_seq;
                if (start_seq) begin
                    state_reg <= SEQ_SYNC;
                end
            end
            SEQ_SYNC:  state_reg <= SEQ_NOOP0;
            SEQ_NOOP0: state_reg <= SEQ_WRCMD;
            SEQ_WRCMD: state_reg <= SEQ_IPROG;
            SEQ_IPROG: state_reg <= SEQ_NOOP1;
            SEQ_NOOP1: state_reg <= SEQ_IDLE;
            default: begin
                state_reg <= SEQ_IDLE;
                csib_reg <= 1'b1;
            end
        endcase
    end
end

// word loaded on each edge; idle keeps the dummy word ready
always_comb begin
    case (state_reg)
        SEQ_SYNC:  word_next = ICAP_SYNC;
        SEQ_NOOP0: word_next = ICAP_NOOP;
        SEQ_WRCMD: word_next = ICAP_WRITE_CMD;
        SEQ_IPROG: word_next = ICAP_IPROG;
        SEQ_NOOP1: word_next = ICAP_NOOP;
        default:   word_next = ICAP_DUMMY;
    endcase
end

always_ff @(posedge clk_125mhz_int) begin
    word_reg <= word_next;
end

// config port takes each byte with its bits swapped
always_comb begin
    for (int b = 0; b < $bits(icap_word_t) / 8; b++) begin
        for (int i = 0; i < 8; i++) begin
            icap_di[8*b + i] = word_reg[8*b + 7 - i];
        end
    end
end

assign icap_csib = csib_reg;

endmodule

// ==== verilog/pcs_status_mon.sv ====
// PCS speed decode and LED select
module pcs_status_mon (
    input  logic                      clk_125mhz_int,
    input  logic                      rst,
    input  board_io_pkg::gpio_raw_t   gpio_db,
    input  board_io_pkg::pcs_status_t pcs_status,
    output logic                      speed_is_10_100,
    output logic                      speed_is_100,
    output board_io_pkg::led_t        led
);

import board_io_pkg::*;

led_t led_next;

// speed hints back to the PCS, straight from the status field
assign speed_is_10_100 = (pcs_status.speed != SPEED_1000);
assign speed_is_100 = (pcs_status.speed == SPEED_100);

// sw[3] selects debug view, sw[0] picks the status byte
always_comb begin
    if (!gpio_db.sw[3]) begin
        led_next = {
            gpio_db.btnu,
            gpio_db.btnl,
            gpio_db.btnd,
            gpio_db.btnr,
            gpio_db.btnc,
            gpio_db.sw[2:0]
        };
    end else if (gpio_db.sw[0]) begin
        led_next = pcs_status[15:8];
    end else begin
        led_next = pcs_status[7:0];
    end
end

always_ff @(posedge clk_125mhz_int) begin
    if (rst) begin
        led <= '0;
    end else begin
        led <= led_next;
    end
end

endmodule
